// File: fpga_board_top.f
common/board_pkg.sv
common/uart_pkg.sv
design/clk_pll_model.sv
uart/uart_tx.sv
uart/uart_rx.sv
design/console_ctrl.sv
design/fpga_board_top.sv
bench/console_checker.sv
bench/fpga_board_top_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator; pass is decided from the log.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --timescale 1ns/100ps \
  --top-module fpga_board_top_tb \
  -f fpga_board_top.f \
  -o fpga_board_top_sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/fpga_board_top_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "RESULT: PASS" "$LOG"; then
  exit 0
fi
exit 1

// File: bench/fpga_board_top_tb.sv
/* Testbench for the board wrapper. Drives the UART line, decodes the
   console output and compares it with the expected banner and echoes */
`default_nettype none

module fpga_board_top_tb;

  import board_pkg::*;
  import uart_pkg::*;

  timeunit 1ns;
  timeprecision 100ps;

  typedef logic [7:0] byte_q_t[$];

  localparam int BOARD_PER_BIT = CLKS_PER_BIT * 2;
  localparam int RX_LIMIT      = 400;

  logic        clk_i;
  logic        rst_n_i;
  logic        boot_select_i;
  logic        uart_rx_i;
  wire         uart_tx_o;
  wire         rst_led_o;
  wire         clk_led_o;
  wire         clk_out_o;
  wire         exit_valid_o;
  wire         exit_value_o;
  int          errors;
  int          tests;
  logic [31:0] lfsr;
  byte_q_t     sent_q;
  byte_q_t     got_q;

  fpga_board_top dut0 (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .boot_select_i(boot_select_i),
    .uart_rx_i    (uart_rx_i),
    .uart_tx_o    (uart_tx_o),
    .rst_led_o    (rst_led_o),
    .clk_led_o    (clk_led_o),
    .clk_out_o    (clk_out_o),
    .exit_valid_o (exit_valid_o),
    .exit_value_o (exit_value_o)
  );

  bind console_ctrl console_checker chk0 (
    .clk_gen   (clk_gen),
    .rst_n     (rst_n),
    .tx_start  (tx_start),
    .tx_busy   (tx_busy),
    .exit_valid(exit_valid_o),
    .state     (state)
  );

  always #10 clk_i = ~clk_i;

  // banner followed by every sent byte in order
  function automatic byte_q_t expected_stream(input logic sel, input byte_q_t sent);
    byte_q_t q;
    string   banner;
    banner = sel ? "JTAG" : "BOOT";
    for (int i = 0; i < 4; i++) begin
      q.push_back(banner[i]);
    end
    foreach (sent[i]) begin
      q.push_back(sent[i]);
    end
    return q;
  endfunction

  // taps 32 22 2 1
  function automatic logic [7:0] random_byte();
    logic       fb;
    logic [7:0] b;
    for (int i = 0; i < 8; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      b[i] = fb;
    end
    return b;
  endfunction

  task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
    assert (got === exp)
    else begin
      $display("CHECK FAILED at %0d ns: %s expected %02h got %02h", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("TIMEOUT at %0d ns: no %s", $time, what);
    errors++;
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests++;
    $display("test %0d %s: %s", tests, name, (errors == err_before) ? "ok" : "errors");
  endtask

  task automatic hold_bit(input logic v);
    uart_rx_i = v;
    repeat (BOARD_PER_BIT) @(posedge clk_i);
    #2;
  endtask

  task automatic send_byte(input logic [7:0] data, input logic stop_bit);
    @(posedge clk_i);
    #2;
    hold_bit(1'b0);
    for (int i = 0; i < 8; i++) begin
      hold_bit(data[i]);
    end
    hold_bit(stop_bit);
    hold_bit(1'b1);
  endtask

  // sampled on falling board edges between clk_gen updates
  task automatic recv_byte(output logic [7:0] data, output logic seen);
    int n;
    n    = 0;
    seen = 1'b0;
    data = '0;
    while ((uart_tx_o !== 1'b0) && (n < RX_LIMIT)) begin
      @(negedge clk_i);
      n++;
    end
    if (uart_tx_o === 1'b0) begin
      seen = 1'b1;
      repeat (BOARD_PER_BIT / 2) @(negedge clk_i);
      check_value("uart_tx_o start bit", {7'd0, uart_tx_o}, 8'h00);
      for (int i = 0; i < 8; i++) begin
        repeat (BOARD_PER_BIT) @(negedge clk_i);
        data[i] = uart_tx_o;
      end
      repeat (BOARD_PER_BIT) @(negedge clk_i);
      check_value("uart_tx_o stop bit", {7'd0, uart_tx_o}, 8'h01);
    end
  endtask

  task automatic expect_byte(input logic [7:0] sent);
    logic [7:0] got;
    logic       seen;
    fork
      send_byte(sent, 1'b1);
      recv_byte(got, seen);
    join
    if (seen) begin
      got_q.push_back(got);
    end else begin
      report_timeout("echo on uart_tx_o");
    end
  endtask

  task automatic compare_stream(input byte_q_t exp);
    check_value("byte count on uart_tx_o", 8'(got_q.size()), 8'(exp.size()));
    foreach (exp[i]) begin
      if (i < got_q.size()) begin
        check_value($sformatf("uart_tx_o byte %0d", i), got_q[i], exp[i]);
      end
    end
  endtask

  task automatic apply_reset(input logic sel);
    int n;
    @(posedge clk_i);
    #2;
    rst_n_i       = 1'b0;
    boot_select_i = sel;
    repeat (5) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    n       = 0;
    while (!rst_led_o && (n < 200)) begin
      @(negedge clk_i);
      n++;
    end
    if (!rst_led_o) begin
      report_timeout("reset release on rst_led_o");
    end
    // core reset must wait for lock
    assert (n >= PLL_LOCK_CYCLES)
    else begin
      $display("rst_led_o rose after %0d board cycles, before PLL lock", n);
      errors++;
    end
    sent_q.delete();
    got_q.delete();
  endtask

  task automatic receive_banner();
    logic [7:0] got;
    logic       seen;
    for (int i = 0; i < 4; i++) begin
      recv_byte(got, seen);
      if (seen) begin
        got_q.push_back(got);
      end else begin
        report_timeout("banner byte on uart_tx_o");
      end
    end
  endtask

  task automatic wait_exit(input logic exp_value);
    int n;
    n = 0;
    while (!exit_valid_o && (n < RX_LIMIT)) begin
      @(negedge clk_i);
      n++;
    end
    if (!exit_valid_o) begin
      report_timeout("exit_valid_o");
    end
    check_value("exit_value_o", {7'd0, exit_value_o}, {7'd0, exp_value});
  endtask

  task automatic heartbeat_period(output int edges);
    logic last;
    int   n;
    n     = 0;
    edges = 0;
    last  = clk_led_o;
    while ((clk_led_o === last) && (n < 200)) begin
      @(negedge clk_out_o);
      n++;
    end
    last = clk_led_o;
    while ((clk_led_o === last) && (edges < 200)) begin
      @(negedge clk_out_o);
      edges++;
    end
  endtask

  initial begin
    logic [7:0] b;
    logic [7:0] got;
    logic       seen;
    int         err0;
    int         edges;
    clk_i         = 1'b0;
    rst_n_i       = 1'b0;
    boot_select_i = 1'b0;
    uart_rx_i     = 1'b1;
    errors        = 0;
    tests         = 0;
    lfsr          = 32'h1ea6_d26c;

    err0 = errors;
    apply_reset(1'b0);
    heartbeat_period(edges);
    check_value("clk_led_o half period", 8'(edges), 8'(1 << (CLK_LED_COUNT_LENGTH - 1)));
    finish_test("reset and heartbeat", err0);

    err0 = errors;
    apply_reset(1'b0);
    receive_banner();
    compare_stream(expected_stream(1'b0, sent_q));
    finish_test("BOOT banner", err0);

    err0 = errors;
    for (int i = 0; i < 6; i++) begin
      b = random_byte();
      while (b == EOT_BYTE) begin
        b = random_byte();
      end
      sent_q.push_back(b);
      expect_byte(b);
    end
    compare_stream(expected_stream(1'b0, sent_q));
    finish_test("random echo", err0);

    err0 = errors;
    fork
      send_byte(EOT_BYTE, 1'b1);
      recv_byte(got, seen);
    join
    assert (!seen)
    else begin
      $display("EOT byte was echoed on uart_tx_o");
      errors++;
    end
    wait_exit(1'b0);
    b = random_byte();
    fork
      send_byte(b, 1'b1);
      recv_byte(got, seen);
    join
    assert (!seen)
    else begin
      $display("byte after EOT produced output on uart_tx_o");
      errors++;
    end
    finish_test("EOT exit", err0);

    err0 = errors;
    apply_reset(1'b1);
    receive_banner();
    send_byte(8'h5a, 1'b0);
    send_byte(EOT_BYTE, 1'b1);
    wait_exit(1'b1);
    compare_stream(expected_stream(1'b1, sent_q));
    finish_test("JTAG banner and framing error", err0);

    $display("tests run %0d, errors %0d", tests, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/console_checker.sv
/* Protocol assertions for the console controller and its transmitter,
   bound into console_ctrl from the testbench */
`default_nettype none

module console_checker
  import uart_pkg::*;
(
  input wire logic           clk_gen,
  input wire logic           rst_n,
  input wire logic           tx_start,
  input wire logic           tx_busy,
  input wire logic           exit_valid,
  input wire console_state_t state
);

  timeunit 1ns;
  timeprecision 100ps;

  // the transmitter takes every start strobe
  busy_after_start: assert property (@(posedge clk_gen) disable iff (!rst_n)
    tx_start |=> tx_busy)
    else $error("tx busy did not rise after a start strobe");

  exit_valid_sticky: assert property (@(posedge clk_gen) disable iff (!rst_n)
    exit_valid |=> exit_valid)
    else $error("exit_valid fell without reset");

  // DONE is terminal
  done_is_final: assert property (@(posedge clk_gen) disable iff (!rst_n)
    (state == DONE) |=> (state == DONE))
    else $error("console state left DONE");

endmodule

`default_nettype wire

// File: design/fpga_board_top.sv
/* FPGA board wrapper around the console system. Generates the core clock,
   holds the core in reset until lock and drives the debug LEDs */
`default_nettype none

module fpga_board_top
  import board_pkg::*;
(
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic boot_select_i,
  input  logic uart_rx_i,
  output logic uart_tx_o,
  output logic rst_led_o,
  output logic clk_led_o,
  output logic clk_out_o,
  output logic exit_valid_o,
  output logic exit_value_o
);

  logic       clk_gen;
  logic       pll_locked;
  logic       rst_gate_n;
  logic       rst_sync;
  logic       rst_n;
  led_count_t clk_count;

  clk_pll_model clk_pll_model_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .clk_o   (clk_gen),
    .locked_o(pll_locked)
  );

  // pin reset or loss of lock asserts at once, release takes two edges
  assign rst_gate_n = rst_n_i & pll_locked;

  always_ff @(posedge clk_gen or negedge rst_gate_n) begin
    if (!rst_gate_n) begin
      rst_sync <= 1'b0;
      rst_n    <= 1'b0;
    end else begin
      rst_sync <= 1'b1;
      rst_n    <= rst_sync;
    end
  end

  // heartbeat
  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      clk_count <= '0;
    end else begin
      clk_count <= clk_count + 1'b1;
    end
  end

  assign rst_led_o = rst_n;
  assign clk_led_o = clk_count[CLK_LED_COUNT_LENGTH-1];
  assign clk_out_o = clk_gen;

  console_ctrl console_ctrl_i (
    .clk_gen      (clk_gen),
    .rst_n        (rst_n),
    .boot_select_i(boot_select_i),
    .rx_i         (uart_rx_i),
    .tx_o         (uart_tx_o),
    .exit_valid_o (exit_valid_o),
    .exit_value_o (exit_value_o)
  );

endmodule

`default_nettype wire

// File: design/console_ctrl.sv
/* Console system. Sends a boot banner chosen at reset release, echoes
   received bytes through a one-entry buffer and reports exit on EOT */
`default_nettype none

module console_ctrl
  import uart_pkg::*;
(
  input  logic clk_gen,
  input  logic rst_n,
  input  logic boot_select_i,
  input  logic rx_i,
  output logic tx_o,
  output logic exit_valid_o,
  output logic exit_value_o
);

  console_state_t state;
  logic           sel_valid;
  logic           boot_sel_q;
  banner_idx_t    banner_idx;
  logic           pend_valid;
  byte_t          pend_data;
  logic           err_flag;
  logic           banner_go;
  logic           pend_take;
  logic           pend_load;
  logic           rx_accept;
  logic           tx_start;
  logic           tx_busy;
  byte_t          tx_data;
  logic           rx_valid;
  byte_t          rx_data;
  logic           rx_frame_err;

  assign banner_go = (state == BANNER) && sel_valid;
  assign tx_start  = !tx_busy && (banner_go || ((state != BANNER) && pend_valid));
  assign pend_take = tx_start && (state != BANNER);

  // bytes with a bad stop bit are not echoed, only flagged
  assign rx_accept = rx_valid && (state != DONE) && !rx_frame_err && (rx_data != EOT_BYTE);
  assign pend_load = rx_accept && (!pend_valid || pend_take);

  always_comb begin
    if (!banner_go) begin
      tx_data = pend_data;
    end else if (boot_sel_q) begin
      tx_data = BANNER_JTAG[banner_idx];
    end else begin
      tx_data = BANNER_BOOT[banner_idx];
    end
  end

  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      state        <= BANNER;
      sel_valid    <= 1'b0;
      boot_sel_q   <= 1'b0;
      banner_idx   <= '0;
      pend_valid   <= 1'b0;
      err_flag     <= 1'b0;
      exit_valid_o <= 1'b0;
      exit_value_o <= 1'b0;
    end else begin
      // first cycle out of reset
      if (!sel_valid) begin
        sel_valid  <= 1'b1;
        boot_sel_q <= boot_select_i;
      end
      if (banner_go && tx_start) begin
        banner_idx <= banner_idx + 1'b1;
        if (banner_idx == banner_idx_t'(BANNER_LEN - 1)) begin
          state <= ECHO;
        end
      end
      if (pend_load) begin
        pend_valid <= 1'b1;
      end else if (pend_take) begin
        pend_valid <= 1'b0;
      end
      if (rx_valid && (state != DONE)) begin
        if (rx_frame_err || (rx_accept && !pend_load)) begin
          err_flag <= 1'b1;
        end else if (rx_data == EOT_BYTE) begin
          state        <= DONE;
          exit_valid_o <= 1'b1;
          exit_value_o <= err_flag;
        end
      end
    end
  end

  always_ff @(posedge clk_gen) begin
    if (pend_load) begin
      pend_data <= rx_data;
    end
  end

  uart_tx uart_tx_i (
    .clk_gen   (clk_gen),
    .rst_n     (rst_n),
    .tx_start_i(tx_start),
    .tx_data_i (tx_data),
    .tx_o      (tx_o),
    .tx_busy_o (tx_busy)
  );

  uart_rx uart_rx_i (
    .clk_gen       (clk_gen),
    .rst_n         (rst_n),
    .rx_i          (rx_i),
    .rx_valid_o    (rx_valid),
    .rx_data_o     (rx_data),
    .rx_frame_err_o(rx_frame_err)
  );

endmodule

`default_nettype wire

// File: uart/uart_rx.sv
/* 8N1 UART receiver. Synchronizes the line, finds the start bit and samples
   each bit at its middle. Pulses valid mid stop bit with a framing error flag */
`default_nettype none

module uart_rx
  import uart_pkg::*;
(
  input  logic  clk_gen,
  input  logic  rst_n,
  input  logic  rx_i,
  output logic  rx_valid_o,
  output byte_t rx_data_o,
  output logic  rx_frame_err_o
);

  rx_state_t state;
  logic      rx_meta;
  logic      rx_sync;
  baud_cnt_t baud_cnt;
  bit_cnt_t  bit_cnt;
  byte_t     shift_q;
  logic      line_wait;

  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx_i;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      state          <= RX_IDLE;
      baud_cnt       <= '0;
      bit_cnt        <= '0;
      line_wait      <= 1'b0;
      rx_valid_o     <= 1'b0;
      rx_frame_err_o <= 1'b0;
    end else begin
      rx_valid_o <= 1'b0;
      baud_cnt   <= baud_cnt + 1'b1;
      case (state)
        RX_IDLE: begin
          baud_cnt <= '0;
          if (!rx_sync) begin
            state <= RX_START;
          end
        end
        RX_START: begin
          // still low at mid start bit, else a glitch
          if (baud_cnt == BAUD_HALF) begin
            baud_cnt <= '0;
            bit_cnt  <= '0;
            state    <= rx_sync ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          if (baud_cnt == BAUD_LAST) begin
            baud_cnt <= '0;
            bit_cnt  <= bit_cnt + 1'b1;
            if (bit_cnt == LAST_DATA_BIT) begin
              state <= RX_STOP;
            end
          end
        end
        default: begin
          if (line_wait) begin
            // broken stop bit, wait for the line to go idle
            if (rx_sync) begin
              line_wait <= 1'b0;
              state     <= RX_IDLE;
            end
          end else if (baud_cnt == BAUD_LAST) begin
            rx_valid_o     <= 1'b1;
            rx_frame_err_o <= !rx_sync;
            if (rx_sync) begin
              state <= RX_IDLE;
            end else begin
              line_wait <= 1'b1;
            end
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_gen) begin
    if ((state == RX_DATA) && (baud_cnt == BAUD_LAST)) begin
      shift_q <= {rx_sync, shift_q[7:1]};
    end
    if ((state == RX_STOP) && !line_wait && (baud_cnt == BAUD_LAST)) begin
      rx_data_o <= shift_q;
    end
  end

endmodule

`default_nettype wire

// File: uart/uart_tx.sv
/* 8N1 UART transmitter. A start strobe while idle loads the byte,
   which then goes out LSB first framed by a start and a stop bit */
`default_nettype none

module uart_tx
  import uart_pkg::*;
(
  input  logic  clk_gen,
  input  logic  rst_n,
  input  logic  tx_start_i,
  input  byte_t tx_data_i,
  output logic  tx_o,
  output logic  tx_busy_o
);

  tx_state_t state;
  baud_cnt_t baud_cnt;
  bit_cnt_t  bit_cnt;
  byte_t     shift_q;

  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      state     <= TX_IDLE;
      baud_cnt  <= '0;
      bit_cnt   <= '0;
      tx_o      <= 1'b1;
      tx_busy_o <= 1'b0;
    end else begin
      baud_cnt <= (baud_cnt == BAUD_LAST) ? '0 : baud_cnt + 1'b1;
      case (state)
        TX_IDLE: begin
          baud_cnt <= '0;
          if (tx_start_i) begin
            state     <= TX_START;
            tx_o      <= 1'b0;
            tx_busy_o <= 1'b1;
          end
        end
        TX_START: begin
          if (baud_cnt == BAUD_LAST) begin
            state   <= TX_DATA;
            bit_cnt <= '0;
            tx_o    <= shift_q[0];
          end
        end
        TX_DATA: begin
          if (baud_cnt == BAUD_LAST) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == LAST_DATA_BIT) begin
              state <= TX_STOP;
              tx_o  <= 1'b1;
            end else begin
              tx_o <= shift_q[0];
            end
          end
        end
        default: begin
          if (baud_cnt == BAUD_LAST) begin
            state     <= TX_IDLE;
            tx_busy_o <= 1'b0;
          end
        end
      endcase
    end
  end

  // shifts one bit each time a bit goes on the line
  always_ff @(posedge clk_gen) begin
    if ((state == TX_IDLE) && tx_start_i) begin
      shift_q <= tx_data_i;
    end else if ((state != TX_IDLE) && (state != TX_STOP) && (baud_cnt == BAUD_LAST)) begin
      shift_q <= shift_q >> 1;
    end
  end

endmodule

`default_nettype wire

// File: design/clk_pll_model.sv
/* Behavioral stand-in for the vendor clock wizard. Halves the board
   clock and raises lock a fixed number of board cycles after reset */
`default_nettype none

module clk_pll_model
  import board_pkg::*;
(
  input  logic clk_i,
  input  logic rst_n_i,
  output logic clk_o,
  output logic locked_o
);

  lock_cnt_t lock_cnt;

  // divide by two
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      clk_o <= 1'b0;
    end else begin
      clk_o <= ~clk_o;
    end
  end

  // saturates once lock is reached
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lock_cnt <= '0;
    end else if (lock_cnt != lock_cnt_t'(PLL_LOCK_CYCLES)) begin
      lock_cnt <= lock_cnt + 1'b1;
    end
  end

  assign locked_o = (lock_cnt == lock_cnt_t'(PLL_LOCK_CYCLES));

endmodule

`default_nettype wire

// File: common/uart_pkg.sv
/* UART bit timing, data and counter types, and the console constants
   (boot banners, end byte, state encodings) */
`default_nettype none

package uart_pkg;

  localparam int CLKS_PER_BIT = 8;

  typedef logic [7:0] byte_t;
  typedef logic [3:0] bit_cnt_t;
  typedef logic [3:0] baud_cnt_t;
  typedef logic [1:0] banner_idx_t;

  localparam baud_cnt_t BAUD_LAST     = baud_cnt_t'(CLKS_PER_BIT - 1);
  localparam baud_cnt_t BAUD_HALF     = baud_cnt_t'(CLKS_PER_BIT / 2 - 1);
  localparam bit_cnt_t  LAST_DATA_BIT = bit_cnt_t'(7);

  localparam int BANNER_LEN = 4;

  // "BOOT" and "JTAG", first byte sent first
  localparam byte_t BANNER_BOOT [BANNER_LEN] = '{8'h42, 8'h4f, 8'h4f, 8'h54};
  localparam byte_t BANNER_JTAG [BANNER_LEN] = '{8'h4a, 8'h54, 8'h41, 8'h47};

  // end of transmission ends the console session
  localparam byte_t EOT_BYTE = 8'h04;

  typedef enum logic [1:0] {BANNER, ECHO, DONE} console_state_t;
  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;
  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

endpackage

`default_nettype wire

// File: common/board_pkg.sv
/* Board-level constants for the clock generator model and the
   heartbeat LED counter, imported by the board wrapper and the PLL model */
`default_nettype none

package board_pkg;

  // board clock cycles from reset release until lock
  localparam int PLL_LOCK_CYCLES = 16;
  localparam int LOCK_CNT_W      = $clog2(PLL_LOCK_CYCLES + 1);

  // kept short so the LED visibly toggles in simulation
  localparam int CLK_LED_COUNT_LENGTH = 6;

  typedef logic [LOCK_CNT_W-1:0]           lock_cnt_t;
  typedef logic [CLK_LED_COUNT_LENGTH-1:0] led_count_t;

endpackage

`default_nettype wire
